/* project.f */
cpu_pkg.sv
mem_req_if.sv
instr_decoder.sv
alu.sv
register_file.sv
fetch_unit.sv
load_store_unit.sv
bus_arbiter.sv
wishbone_master.sv
cpu_core.sv
rv_soc_top.sv
tb_wb_memory.sv
tb_rv_soc_top.sv

/* tb_rv_soc_top.sv */
// ##############################
// tb_rv_soc_top
// runs the program on rv_soc_top and checks
// every Wishbone write against a table
// ##############################
`default_nettype none

module tb_rv_soc_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] PROGRAM_BASE     = 32'h3300_0000;
    localparam int          NUM_WRITES       = 26;
    localparam int          CYCLES_PER_WRITE = 40;

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic [3:0]  wb_sel;
    logic        wb_we;
    logic        wb_stb;
    logic        wb_cyc;
    logic        wb_ack;

    logic        open_q = 1'b0;   // a cycle was seen without ack
    logic [31:0] adr_q;
    logic [31:0] dat_q;
    logic        we_q;

    // address and data of each store, in program order
    logic [31:0] exp_table [NUM_WRITES][2] = '{
        '{32'h3300_0300, 32'h0000_005D},   // add
        '{32'h3300_0304, 32'h0000_006B},   // sub
        '{32'h3300_0308, 32'hFFFF_FF9D},   // xor
        '{32'h3300_030C, 32'hFFFF_FFFD},   // or
        '{32'h3300_0310, 32'h0000_0060},   // and
        '{32'h3300_0314, 32'hFFFF_FFC8},   // sll
        '{32'h3300_0318, 32'h1FFF_FFFF},   // srl
        '{32'h3300_031C, 32'h0000_0094},   // xori
        '{32'h3300_0320, 32'hFFFF_FF64},   // ori
        '{32'h3300_0324, 32'h0000_07F0},   // andi
        '{32'h3300_0328, 32'h0640_0000},   // slli
        '{32'h3300_032C, 32'h0000_000F},   // srli
        '{32'h3300_0330, 32'hABCD_E000},   // lui
        '{32'h3300_0334, 32'h1234_5668},   // load plus -16
        '{32'h3300_0338, 32'h8000_0001},   // load as is
        '{32'h3300_033C, 32'h0000_005D},   // x5 kept
        '{32'h3300_0340, 32'h0000_0010},   // beq taken
        '{32'h3300_0344, 32'h0000_0021},   // beq not taken
        '{32'h3300_0348, 32'h0000_0012},   // bne taken
        '{32'h3300_034C, 32'h0000_0023},   // bne not taken
        '{32'h3300_0350, 32'h0000_0014},   // blt taken, signed
        '{32'h3300_0354, 32'h0000_0025},   // blt not taken
        '{32'h3300_0358, 32'h0000_0016},   // bge taken
        '{32'h3300_035C, 32'h0000_0027},   // bge not taken
        '{32'h3300_0360, 32'h3300_0124},   // jal link
        '{32'h3300_0364, 32'h3300_0134}    // jalr link
    };

    always #50 clk = ~clk;

    rv_soc_top dut (
        .clk(clk), .rst(rst), .wb_dat_i(wb_dat_r), .wb_ack_i(wb_ack),
        .wb_adr_o(wb_adr), .wb_dat_o(wb_dat_w), .wb_sel_o(wb_sel),
        .wb_we_o(wb_we), .wb_stb_o(wb_stb), .wb_cyc_o(wb_cyc)
    );

    tb_wb_memory #(.BASE_ADDR(PROGRAM_BASE), .SEED(32'd86)) u_memory (
        .clk(clk), .rst(rst), .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .wb_we_i(wb_we),
        .wb_stb_i(wb_stb), .wb_cyc_i(wb_cyc), .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack)
    );

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // edge where the slave's ack closes a write
    task automatic wait_for_write();
        do begin
            @(posedge clk);
        end while (!(wb_cyc && wb_stb && wb_we && wb_ack));
    endtask

    // request must hold until ack
    always @(posedge clk) begin
        if (open_q) begin
            compare_word("wb_stb_o", 32'(wb_stb), 32'd1);
            compare_word("wb_adr_o", wb_adr, adr_q);
            compare_word("wb_dat_o", wb_dat_w, dat_q);
            compare_word("wb_we_o", 32'(wb_we), 32'(we_q));
        end
        open_q <= !rst && wb_stb && !wb_ack;
        adr_q  <= wb_adr;
        dat_q  <= wb_dat_w;
        we_q   <= wb_we;
    end

    initial begin
        rst = 1'b1;
        repeat (7) @(posedge clk);
        @(negedge clk);
        compare_word("wb_cyc_o", 32'(wb_cyc), 32'd0);
        compare_word("wb_stb_o", 32'(wb_stb), 32'd0);
        @(posedge clk);
        rst <= 1'b0;   // 8 cycles
        do begin
            @(posedge clk);
        end while (wb_stb !== 1'b1);
        // first access is the fetch at the reset pc
        compare_word("wb_cyc_o", 32'(wb_cyc), 32'd1);
        compare_word("wb_adr_o", wb_adr, PROGRAM_BASE);
        compare_word("wb_we_o", 32'(wb_we), 32'd0);
        compare_word("wb_sel_o", 32'(wb_sel), 32'hF);
        for (int n = 0; n < NUM_WRITES; n++) begin
            wait_for_write();
            compare_word("wb_adr_o", wb_adr, exp_table[n][0]);
            compare_word("wb_dat_o", wb_dat_w, exp_table[n][1]);
        end
        $display("TEST OK");
        $finish;
    end

    initial begin
        repeat (NUM_WRITES * CYCLES_PER_WRITE) @(posedge clk);
        $display("run timed out: not all %0d stores seen after %0d cycles",
                 NUM_WRITES, NUM_WRITES * CYCLES_PER_WRITE);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* tb_wb_memory.sv */
// ##############################
// tb_wb_memory
// Wishbone slave memory with the test program,
// a preloaded data area and random ACK delay
// ##############################
`default_nettype none

module tb_wb_memory #(
    parameter logic [31:0] BASE_ADDR = 32'h3300_0000,
    parameter logic [31:0] SEED      = 32'd86
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] wb_adr_i,
    input  logic [31:0] wb_dat_i,
    input  logic        wb_we_i,
    input  logic        wb_stb_i,
    input  logic        wb_cyc_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DEPTH = 256;

    // rv32i major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // branch cases 0..7: funct3, rs1, rs2, even cases are taken
    localparam logic [7:0][2:0] BR_F3  = {3'b101, 3'b101, 3'b100, 3'b100,
                                          3'b001, 3'b001, 3'b000, 3'b000};
    localparam logic [7:0][4:0] BR_RS1 = {5'd4, 5'd3, 5'd3, 5'd4, 5'd3, 5'd3, 5'd3, 5'd3};
    localparam logic [7:0][4:0] BR_RS2 = {5'd3, 5'd4, 5'd4, 5'd3, 5'd3, 5'd4, 5'd4, 5'd3};

    logic [31:0] mem [DEPTH];
    logic [31:0] seed_q;
    logic [1:0]  wait_q;
    logic        armed_q;
    logic [7:0]  idx;

    assign idx = wb_adr_i[9:2];

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, OPC_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [4:0] rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                           input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] u_type(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    initial begin
        wb_ack_o = 1'b0;
        wb_dat_o = '0;
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = (BASE_ADDR + 32'(4 * i)) ^ 32'h5A5A_A5A5;   // unique per word
        end
        mem[0]  = u_type(5'd1, BASE_ADDR[31:12]);                 // x1 = base
        mem[1]  = i_type(OPC_IMM, 3'b000, 5'd2, 5'd1, 12'h300);   // x2 = result area
        mem[2]  = i_type(OPC_IMM, 3'b000, 5'd3, 5'd0, 12'd100);
        mem[3]  = i_type(OPC_IMM, 3'b000, 5'd4, 5'd0, 12'hFF9);   // -7
        mem[4]  = r_type(7'h00, 3'b000, 5'd5, 5'd3, 5'd4);        // add
        mem[5]  = s_type(5'd5, 5'd2, 12'd0);
        mem[6]  = r_type(7'h20, 3'b000, 5'd6, 5'd3, 5'd4);        // sub
        mem[7]  = s_type(5'd6, 5'd2, 12'd4);
        mem[8]  = r_type(7'h00, 3'b100, 5'd7, 5'd3, 5'd4);        // xor
        mem[9]  = s_type(5'd7, 5'd2, 12'd8);
        mem[10] = r_type(7'h00, 3'b110, 5'd8, 5'd3, 5'd4);        // or
        mem[11] = s_type(5'd8, 5'd2, 12'd12);
        mem[12] = r_type(7'h00, 3'b111, 5'd9, 5'd3, 5'd4);        // and
        mem[13] = s_type(5'd9, 5'd2, 12'd16);
        mem[14] = i_type(OPC_IMM, 3'b000, 5'd10, 5'd0, 12'd3);
        mem[15] = r_type(7'h00, 3'b001, 5'd11, 5'd4, 5'd10);      // sll
        mem[16] = s_type(5'd11, 5'd2, 12'd20);
        mem[17] = r_type(7'h00, 3'b101, 5'd12, 5'd4, 5'd10);      // srl
        mem[18] = s_type(5'd12, 5'd2, 12'd24);
        mem[19] = i_type(OPC_IMM, 3'b100, 5'd13, 5'd3, 12'h0F0);  // xori
        mem[20] = s_type(5'd13, 5'd2, 12'd28);
        mem[21] = i_type(OPC_IMM, 3'b110, 5'd14, 5'd3, 12'hF00);  // ori -256
        mem[22] = s_type(5'd14, 5'd2, 12'd32);
        mem[23] = i_type(OPC_IMM, 3'b111, 5'd15, 5'd4, 12'h7F0);  // andi
        mem[24] = s_type(5'd15, 5'd2, 12'd36);
        mem[25] = i_type(OPC_IMM, 3'b001, 5'd16, 5'd3, 12'd20);   // slli
        mem[26] = s_type(5'd16, 5'd2, 12'd40);
        mem[27] = i_type(OPC_IMM, 3'b101, 5'd17, 5'd4, 12'd28);   // srli
        mem[28] = s_type(5'd17, 5'd2, 12'd44);
        mem[29] = u_type(5'd18, 20'hABCDE);
        mem[30] = s_type(5'd18, 5'd2, 12'd48);
        mem[31] = i_type(OPC_LOAD, 3'b010, 5'd19, 5'd1, 12'h200); // lw
        mem[32] = i_type(OPC_IMM, 3'b000, 5'd20, 5'd19, 12'hFF0); // -16
        mem[33] = s_type(5'd20, 5'd2, 12'd52);
        mem[34] = i_type(OPC_LOAD, 3'b010, 5'd21, 5'd1, 12'h204);
        mem[35] = s_type(5'd21, 5'd2, 12'd56);
        mem[36] = i_type(OPC_IMM, 3'b010, 5'd5, 5'd3, 12'd1);     // slti, a no-op here
        mem[37] = s_type(5'd5, 5'd2, 12'd60);
        // taken marker 0x10+k, overwritten by 0x20+k when the branch falls through
        for (int k = 0; k < 8; k++) begin
            mem[38 + 4 * k] = i_type(OPC_IMM, 3'b000, 5'd22, 5'd0, 12'(16 + k));
            mem[39 + 4 * k] = b_type(BR_F3[k], BR_RS1[k], BR_RS2[k], 13'd8);
            mem[40 + 4 * k] = i_type(OPC_IMM, 3'b000, 5'd22, 5'd0, 12'(32 + k));
            mem[41 + 4 * k] = s_type(5'd22, 5'd2, 12'(64 + 4 * k));
        end
        mem[70] = b_type(3'b000, 5'd0, 5'd0, 13'd8);
        mem[71] = s_type(5'd0, 5'd2, 12'd0);                     // skipped
        mem[72] = j_type(5'd24, 21'd12);
        mem[73] = s_type(5'd0, 5'd2, 12'd4);                     // skipped
        mem[74] = s_type(5'd0, 5'd2, 12'd8);                     // skipped
        mem[75] = s_type(5'd24, 5'd2, 12'd96);
        mem[76] = i_type(OPC_JALR, 3'b000, 5'd26, 5'd1, 12'h13D); // odd target, bit 0 dropped
        mem[77] = s_type(5'd0, 5'd2, 12'd12);                    // skipped
        mem[78] = s_type(5'd0, 5'd2, 12'd16);                    // skipped
        mem[79] = s_type(5'd26, 5'd2, 12'd100);
        mem[80] = j_type(5'd0, 21'd0);                           // park
        mem[128] = 32'h1234_5678;
        mem[129] = 32'h8000_0001;
    end

    // ack after 0 to 3 wait cycles, dropped the edge after it is seen
    always @(posedge clk or posedge rst) begin : ack_gen
        logic [31:0] seed_n;
        logic        fire;
        if (rst) begin
            wb_ack_o <= 1'b0;
            seed_q   <= SEED;
            wait_q   <= '0;
            armed_q  <= 1'b0;
        end else begin
            seed_n = lcg_next(seed_q);
            fire   = 1'b0;
            wb_ack_o <= 1'b0;
            if (wb_cyc_i && wb_stb_i && !wb_ack_o) begin
                if (!armed_q) begin
                    seed_q  <= seed_n;
                    wait_q  <= seed_n[17:16];
                    armed_q <= 1'b1;
                    fire = (seed_n[17:16] == 2'd0);
                end else begin
                    wait_q <= wait_q - 2'd1;
                    fire = (wait_q == 2'd1);
                end
            end
            if (fire) begin
                wb_ack_o <= 1'b1;
                armed_q  <= 1'b0;
                if (wb_we_i) begin
                    mem[idx] <= wb_dat_i;
                end else begin
                    wb_dat_o <= mem[idx];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rv_soc_top.sv */
// ############################
// rv_soc_top
// core, arbiter and Wishbone master
// ############################
`default_nettype none

module rv_soc_top #(
    parameter cpu_pkg::word_t RESET_PC = cpu_pkg::RESET_PC_DEFAULT
) (
    input  logic           clk,
    input  logic           rst,
    input  cpu_pkg::word_t wb_dat_i,
    input  logic           wb_ack_i,
    output cpu_pkg::word_t wb_adr_o,
    output cpu_pkg::word_t wb_dat_o,
    output logic [3:0]     wb_sel_o,
    output logic           wb_we_o,
    output logic           wb_stb_o,
    output logic           wb_cyc_o
);
    mem_req_if fetch_bus ();
    mem_req_if data_bus ();
    mem_req_if master_bus ();

    cpu_core #(.RESET_PC(RESET_PC)) u_core (
        .clk, .rst, .fetch_bus(fetch_bus), .data_bus(data_bus)
    );

    bus_arbiter u_arbiter (
        .clk, .rst, .fetch_port(fetch_bus), .data_port(data_bus), .master_port(master_bus)
    );

    wishbone_master u_master (
        .clk, .rst, .req_port(master_bus), .wb_dat_i, .wb_ack_i, .wb_adr_o,
        .wb_dat_o, .wb_sel_o, .wb_we_o, .wb_stb_o, .wb_cyc_o
    );

endmodule

`default_nettype wire

/* cpu_core.sv */
// ############################
// cpu_core
// multicycle sequencer, writeback and next-pc select
// ############################
`default_nettype none

module cpu_core #(
    parameter cpu_pkg::word_t RESET_PC = cpu_pkg::RESET_PC_DEFAULT
) (
    input  logic         clk,
    input  logic         rst,
    mem_req_if.requester fetch_bus,
    mem_req_if.requester data_bus
);
    cpu_pkg::core_state_e state_q;
    cpu_pkg::word_t       pc, instr, imm, rs1_val, rs2_val, alu_b, alu_result;
    cpu_pkg::word_t       load_data, wb_data, next_pc, pc_plus4;
    cpu_pkg::reg_addr_t   rs1, rs2, rd;
    cpu_pkg::alu_op_t     alu_op;
    logic                 use_imm, is_load, is_store, is_branch, is_jal, is_jalr;
    logic                 dec_reg_we, instr_valid, branch_taken, mem_start, mem_finished;

    assign mem_start = (state_q == cpu_pkg::S_EXECUTE) && (is_load || is_store);
    assign alu_b     = use_imm ? imm : rs2_val;
    assign pc_plus4  = pc + 32'd4;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= cpu_pkg::S_FETCH;
        end else begin
            case (state_q)
                cpu_pkg::S_FETCH:
                    if (instr_valid) state_q <= cpu_pkg::S_EXECUTE;
                cpu_pkg::S_EXECUTE:
                    state_q <= mem_start ? cpu_pkg::S_MEMORY : cpu_pkg::S_WRITEBACK;
                cpu_pkg::S_MEMORY:
                    if (mem_finished) state_q <= cpu_pkg::S_WRITEBACK;
                default: state_q <= cpu_pkg::S_FETCH;   // after writeback
            endcase
        end
    end

    // link value for jumps, load word, else alu
    always_comb begin
        if (is_load) begin
            wb_data = load_data;
        end else if (is_jal || is_jalr) begin
            wb_data = pc_plus4;
        end else begin
            wb_data = alu_result;
        end
    end

    always_comb begin
        if (is_jalr) begin
            next_pc = {alu_result[31:1], 1'b0};
        end else if (is_jal || (is_branch && branch_taken)) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc_plus4;
        end
    end

    instr_decoder u_decoder (
        .instr_i(instr), .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .imm_o(imm),
        .alu_op_o(alu_op), .use_imm_o(use_imm), .is_load_o(is_load),
        .is_store_o(is_store), .is_branch_o(is_branch), .is_jal_o(is_jal),
        .is_jalr_o(is_jalr), .reg_we_o(dec_reg_we)
    );

    alu u_alu (
        .op_i(alu_op), .a_i(rs1_val), .b_i(alu_b), .rs2_val_i(rs2_val),
        .funct3_i(instr[14:12]), .result_o(alu_result), .branch_taken_o(branch_taken)
    );

    register_file u_regs (
        .clk, .rst, .rs1_i(rs1), .rs2_i(rs2), .rd_i(rd),
        .we_i(state_q == cpu_pkg::S_WRITEBACK && dec_reg_we),
        .wdata_i(wb_data), .rs1_val_o(rs1_val), .rs2_val_o(rs2_val)
    );

    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
        .clk, .rst, .fetch_i(state_q == cpu_pkg::S_FETCH),
        .pc_load_i(state_q == cpu_pkg::S_WRITEBACK), .next_pc_i(next_pc),
        .pc_o(pc), .instr_o(instr), .instr_valid_o(instr_valid), .bus(fetch_bus)
    );

    load_store_unit u_lsu (
        .clk, .rst, .start_i(mem_start), .write_i(is_store), .addr_i(alu_result),
        .wdata_i(rs2_val), .load_data_o(load_data), .finished_o(mem_finished),
        .bus(data_bus)
    );

endmodule

`default_nettype wire

/* wishbone_master.sv */
// ############################
// wishbone_master
// one classic single-word cycle per request
// ############################
`default_nettype none

module wishbone_master (
    input  logic           clk,
    input  logic           rst,
    mem_req_if.arbiter     req_port,
    input  cpu_pkg::word_t wb_dat_i,
    input  logic           wb_ack_i,
    output cpu_pkg::word_t wb_adr_o,
    output cpu_pkg::word_t wb_dat_o,
    output logic [3:0]     wb_sel_o,
    output logic           wb_we_o,
    output logic           wb_stb_o,
    output logic           wb_cyc_o
);
    cpu_pkg::wb_state_e state_q;
    logic               done_q;
    cpu_pkg::word_t     rdata_q;

    assign req_port.done  = done_q;
    assign req_port.rdata = rdata_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q  <= cpu_pkg::W_IDLE;
            done_q   <= 1'b0;
            wb_adr_o <= '0;
            wb_dat_o <= '0;
            wb_sel_o <= '0;
            wb_we_o  <= 1'b0;
            wb_stb_o <= 1'b0;
            wb_cyc_o <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                cpu_pkg::W_IDLE: begin
                    // req is still up during the done cycle of the last request
                    if (req_port.req && !done_q) begin
                        state_q  <= cpu_pkg::W_BUSY;
                        wb_adr_o <= req_port.addr;
                        wb_dat_o <= req_port.wdata;
                        wb_sel_o <= 4'hF;   // full words only
                        wb_we_o  <= req_port.we;
                        wb_stb_o <= 1'b1;
                        wb_cyc_o <= 1'b1;
                    end
                end
                cpu_pkg::W_BUSY: begin
                    if (wb_ack_i) begin
                        state_q  <= cpu_pkg::W_IDLE;
                        done_q   <= 1'b1;
                        wb_adr_o <= '0;
                        wb_dat_o <= '0;
                        wb_sel_o <= '0;
                        wb_we_o  <= 1'b0;
                        wb_stb_o <= 1'b0;
                        wb_cyc_o <= 1'b0;
                    end
                end
                default: state_q <= cpu_pkg::W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == cpu_pkg::W_BUSY && wb_ack_i) begin
            rdata_q <= wb_dat_i;
        end
    end

endmodule

`default_nettype wire

/* bus_arbiter.sv */
// ############################
// bus_arbiter
// fixed priority, data ahead of fetch
// ############################
`default_nettype none

module bus_arbiter (
    input  logic         clk,
    input  logic         rst,
    mem_req_if.arbiter   fetch_port,
    mem_req_if.arbiter   data_port,
    mem_req_if.requester master_port
);
    logic busy_q;
    logic grant_data_q;
    logic pick_data;

    // free choice only while no request is open
    assign pick_data = busy_q ? grant_data_q : data_port.req;

    assign master_port.req   = pick_data ? data_port.req   : fetch_port.req;
    assign master_port.we    = pick_data ? data_port.we    : fetch_port.we;
    assign master_port.addr  = pick_data ? data_port.addr  : fetch_port.addr;
    assign master_port.wdata = pick_data ? data_port.wdata : fetch_port.wdata;

    assign data_port.done   = master_port.done && pick_data;
    assign fetch_port.done  = master_port.done && !pick_data;
    assign data_port.rdata  = pick_data ? master_port.rdata : '0;
    assign fetch_port.rdata = pick_data ? '0 : master_port.rdata;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q       <= 1'b0;
            grant_data_q <= 1'b0;
        end else if (!busy_q && (data_port.req || fetch_port.req)) begin
            busy_q       <= 1'b1;
            grant_data_q <= data_port.req;
        end else if (busy_q && master_port.done) begin
            busy_q <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* load_store_unit.sv */
// ############################
// load_store_unit
// holds one data access and keeps the load word
// ############################
`default_nettype none

module load_store_unit (
    input  logic           clk,
    input  logic           rst,
    input  logic           start_i,
    input  logic           write_i,
    input  cpu_pkg::word_t addr_i,
    input  cpu_pkg::word_t wdata_i,
    output cpu_pkg::word_t load_data_o,
    output logic           finished_o,
    mem_req_if.requester   bus
);
    logic           req_q;
    logic           we_q;
    cpu_pkg::word_t addr_q;
    cpu_pkg::word_t wdata_q;
    cpu_pkg::word_t load_q;

    assign bus.req     = req_q;
    assign bus.we      = we_q;
    assign bus.addr    = addr_q;
    assign bus.wdata   = wdata_q;
    assign load_data_o = load_q;
    assign finished_o  = bus.done;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_q <= 1'b0;
        end else if (start_i) begin
            req_q <= 1'b1;
        end else if (bus.done) begin
            req_q <= 1'b0;   // released the edge after done
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            we_q    <= write_i;
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
        end
        if (bus.done) begin
            load_q <= bus.rdata;
        end
    end

endmodule

`default_nettype wire

/* fetch_unit.sv */
// ############################
// fetch_unit
// pc, instruction register and fetch requests
// ############################
`default_nettype none

module fetch_unit #(
    parameter cpu_pkg::word_t RESET_PC = cpu_pkg::RESET_PC_DEFAULT
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           fetch_i,
    input  logic           pc_load_i,
    input  cpu_pkg::word_t next_pc_i,
    output cpu_pkg::word_t pc_o,
    output cpu_pkg::word_t instr_o,
    output logic           instr_valid_o,
    mem_req_if.requester   bus
);
    cpu_pkg::word_t pc_q;
    cpu_pkg::word_t ir_q;

    // reads only, at the current pc
    assign bus.req   = fetch_i;
    assign bus.we    = 1'b0;
    assign bus.addr  = pc_q;
    assign bus.wdata = '0;

    assign pc_o          = pc_q;
    assign instr_o       = ir_q;
    assign instr_valid_o = bus.done;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else if (pc_load_i) begin
            pc_q <= next_pc_i;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.done) begin
            ir_q <= bus.rdata;
        end
    end

endmodule

`default_nettype wire

/* register_file.sv */
// ############################
// register_file
// 32 x 32 registers, two reads, one write
// ############################
`default_nettype none

module register_file (
    input  logic               clk,
    input  logic               rst,
    input  cpu_pkg::reg_addr_t rs1_i,
    input  cpu_pkg::reg_addr_t rs2_i,
    input  cpu_pkg::reg_addr_t rd_i,
    input  logic               we_i,
    input  cpu_pkg::word_t     wdata_i,
    output cpu_pkg::word_t     rs1_val_o,
    output cpu_pkg::word_t     rs2_val_o
);
    cpu_pkg::word_t regs [32];

    assign rs1_val_o = regs[rs1_i];
    assign rs2_val_o = regs[rs2_i];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin  // x0 never written
            regs[rd_i] <= wdata_i;
        end
    end

endmodule

`default_nettype wire

/* alu.sv */
// ############################
// alu
// arithmetic, addresses and the branch compare
// ############################
`default_nettype none

module alu (
    input  cpu_pkg::alu_op_t op_i,
    input  cpu_pkg::word_t   a_i,
    input  cpu_pkg::word_t   b_i,
    input  cpu_pkg::word_t   rs2_val_i,
    input  logic [2:0]       funct3_i,
    output cpu_pkg::word_t   result_o,
    output logic             branch_taken_o
);

    always_comb begin
        case (op_i)
            cpu_pkg::ALU_ADD: result_o = a_i + b_i;
            cpu_pkg::ALU_SUB: result_o = a_i - b_i;
            cpu_pkg::ALU_XOR: result_o = a_i ^ b_i;
            cpu_pkg::ALU_OR:  result_o = a_i | b_i;
            cpu_pkg::ALU_AND: result_o = a_i & b_i;
            cpu_pkg::ALU_SLL: result_o = a_i << b_i[4:0];
            cpu_pkg::ALU_SRL: result_o = a_i >> b_i[4:0];
            cpu_pkg::ALU_LUI: result_o = b_i;   // immediate arrives pre-shifted
            default:          result_o = '0;
        endcase
    end

    // rs1 against rs2, blt and bge are signed
    always_comb begin
        case (funct3_i)
            cpu_pkg::F3_BEQ: branch_taken_o = (a_i == rs2_val_i);
            cpu_pkg::F3_BNE: branch_taken_o = (a_i != rs2_val_i);
            cpu_pkg::F3_BLT: branch_taken_o = ($signed(a_i) < $signed(rs2_val_i));
            cpu_pkg::F3_BGE: branch_taken_o = ($signed(a_i) >= $signed(rs2_val_i));
            default:         branch_taken_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* instr_decoder.sv */
// ############################
// instr_decoder
// fields, sign-extended immediate and control flags
// ############################
`default_nettype none

module instr_decoder (
    input  cpu_pkg::word_t     instr_i,
    output cpu_pkg::reg_addr_t rs1_o,
    output cpu_pkg::reg_addr_t rs2_o,
    output cpu_pkg::reg_addr_t rd_o,
    output cpu_pkg::word_t     imm_o,
    output cpu_pkg::alu_op_t   alu_op_o,
    output logic               use_imm_o,
    output logic               is_load_o,
    output logic               is_store_o,
    output logic               is_branch_o,
    output logic               is_jal_o,
    output logic               is_jalr_o,
    output logic               reg_we_o
);
    cpu_pkg::opcode_t opcode;
    logic [2:0]       funct3;
    logic             alt;      // funct7 bit 5
    cpu_pkg::alu_op_t arith_op;
    logic             arith_ok;
    cpu_pkg::word_t   imm_i, imm_s, imm_b, imm_j, imm_u;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign alt    = instr_i[30];
    assign rs1_o  = instr_i[19:15];
    assign rs2_o  = instr_i[24:20];
    assign rd_o   = instr_i[11:7];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};

    // shared by register and immediate forms
    always_comb begin
        arith_ok = 1'b1;
        arith_op = cpu_pkg::ALU_ADD;
        case (funct3)
            3'b000: begin
                if (alt && opcode == cpu_pkg::OP_R) begin
                    arith_op = cpu_pkg::ALU_SUB;
                end
            end
            3'b100: arith_op = cpu_pkg::ALU_XOR;
            3'b110: arith_op = cpu_pkg::ALU_OR;
            3'b111: arith_op = cpu_pkg::ALU_AND;
            3'b001: arith_op = cpu_pkg::ALU_SLL;
            3'b101: begin
                arith_op = cpu_pkg::ALU_SRL;
                arith_ok = !alt;    // sra is outside the subset
            end
            default: arith_ok = 1'b0;
        endcase
    end

    always_comb begin
        imm_o       = '0;
        alu_op_o    = cpu_pkg::ALU_ADD;
        use_imm_o   = 1'b0;
        is_load_o   = 1'b0;
        is_store_o  = 1'b0;
        is_branch_o = 1'b0;
        is_jal_o    = 1'b0;
        is_jalr_o   = 1'b0;
        reg_we_o    = 1'b0;
        case (opcode)
            cpu_pkg::OP_R: begin
                alu_op_o = arith_op;
                reg_we_o = arith_ok;
            end
            cpu_pkg::OP_I: begin
                imm_o     = imm_i;
                alu_op_o  = arith_op;
                use_imm_o = 1'b1;
                reg_we_o  = arith_ok;
            end
            cpu_pkg::OP_LOAD: begin
                imm_o     = imm_i;
                use_imm_o = 1'b1;
                is_load_o = (funct3 == 3'b010);   // lw only
                reg_we_o  = (funct3 == 3'b010);
            end
            cpu_pkg::OP_STORE: begin
                imm_o      = imm_s;
                use_imm_o  = 1'b1;
                is_store_o = (funct3 == 3'b010);  // sw only
            end
            cpu_pkg::OP_BRANCH: begin
                imm_o       = imm_b;
                is_branch_o = funct3 inside {cpu_pkg::F3_BEQ, cpu_pkg::F3_BNE,
                                             cpu_pkg::F3_BLT, cpu_pkg::F3_BGE};
            end
            cpu_pkg::OP_JAL: begin
                imm_o    = imm_j;
                is_jal_o = 1'b1;
                reg_we_o = 1'b1;
            end
            cpu_pkg::OP_JALR: begin
                imm_o     = imm_i;
                use_imm_o = 1'b1;
                is_jalr_o = (funct3 == 3'b000);
                reg_we_o  = (funct3 == 3'b000);
            end
            cpu_pkg::OP_LUI: begin
                imm_o     = imm_u;
                alu_op_o  = cpu_pkg::ALU_LUI;
                use_imm_o = 1'b1;
                reg_we_o  = 1'b1;
            end
            default: ;   // no-op, pc advances by 4
        endcase
    end

endmodule

`default_nettype wire

/* mem_req_if.sv */
// ############################
// mem_req_if
// one word request toward the bus arbiter or master
// ############################
`default_nettype none

interface mem_req_if;
    logic           req;    // held until done
    logic           we;
    cpu_pkg::word_t addr;
    cpu_pkg::word_t wdata;
    cpu_pkg::word_t rdata;  // valid while done is high
    logic           done;   // single-cycle pulse

    modport requester (output req, we, addr, wdata, input rdata, done);
    modport arbiter (input req, we, addr, wdata, output rdata, done);
endinterface

`default_nettype wire

/* cpu_pkg.sv */
// ############################
// cpu_pkg
// word types, RV32I encodings and the FSM state types
// ############################
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [3:0]  alu_op_t;

    // base opcodes of the supported subset
    localparam opcode_t OP_R      = 7'b0110011;
    localparam opcode_t OP_I      = 7'b0010011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_LUI    = 7'b0110111;

    localparam alu_op_t ALU_ADD = 4'd0;
    localparam alu_op_t ALU_SUB = 4'd1;
    localparam alu_op_t ALU_XOR = 4'd2;
    localparam alu_op_t ALU_OR  = 4'd3;
    localparam alu_op_t ALU_AND = 4'd4;
    localparam alu_op_t ALU_SLL = 4'd5;
    localparam alu_op_t ALU_SRL = 4'd6;
    localparam alu_op_t ALU_LUI = 4'd7;

    // branch funct3
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

    typedef enum logic [1:0] {
        S_FETCH,
        S_EXECUTE,
        S_MEMORY,
        S_WRITEBACK
    } core_state_e;

    typedef enum logic {
        W_IDLE,
        W_BUSY
    } wb_state_e;

    localparam word_t RESET_PC_DEFAULT = 32'h3300_0000;

endpackage

`default_nettype wire
